// ==== ladder_pkg.sv ====
package ladder_pkg;

    // ========================================
    // Widths and field constants
    // ========================================
    localparam int FE_WIDTH   = 255;
    localparam int EXT_WIDTH  = 256;
    localparam int WIDE_WIDTH = 512;

    typedef logic [FE_WIDTH-1:0]   fe_t;
    typedef logic [EXT_WIDTH-1:0]  fe_ext_t;
    typedef logic [WIDE_WIDTH-1:0] wide_t;

    // p = 2^255 - 19
    localparam fe_t PRIME  = fe_t'((256'd1 << 255) - 256'd19);
    localparam fe_t A24    = fe_t'(121666);
    localparam fe_t BASE_X = fe_t'(9);

    typedef struct packed {
        fe_t x;
        fe_t z;
    } fe_point_t;

    // ========================================
    // Sequencer states
    // ========================================
    typedef enum logic [3:0] {
        XD_IDLE, XD_WAIT_M1, XD_WAIT_R1, XD_WAIT_M2, XD_WAIT_R2, XD_WAIT_M3,
        XD_WAIT_R3, XD_WAIT_M4, XD_WAIT_R4, XD_WAIT_M5, XD_WAIT_R5
    } xdbl_state_t;

    typedef enum logic [3:0] {
        XA_IDLE, XA_WAIT_M1, XA_WAIT_R1, XA_WAIT_M2, XA_WAIT_R2, XA_WAIT_M3,
        XA_WAIT_R3, XA_WAIT_M4, XA_WAIT_R4, XA_WAIT_M5, XA_WAIT_R5
    } xadd_state_t;

    // Both operands below p, so one conditional subtract is enough
    function automatic fe_t fe_add(input fe_t a, input fe_t b);
        fe_ext_t sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= {1'b0, PRIME})
            sum = sum - {1'b0, PRIME};
        return sum[FE_WIDTH-1:0];
    endfunction

    function automatic fe_t fe_sub(input fe_t a, input fe_t b);
        fe_ext_t dif;
        if (a >= b)
            dif = {1'b0, a} - {1'b0, b};
        else
            dif = {1'b0, a} + {1'b0, PRIME} - {1'b0, b};
        return dif[FE_WIDTH-1:0];
    endfunction

endpackage

// ==== ladder_step.sv ====
`timescale 1ns/1ps

module ladder_step import ladder_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  fe_point_t p_point,
    input  fe_point_t q_point,
    input  fe_point_t dbl_point,
    output fe_point_t add_point,
    output fe_point_t dbl_out,
    output logic      done
);

    logic dbl_done;
    logic add_done;
    logic dbl_fin;
    logic add_fin;
    logic both_fin;

    xdbl_unit u_dbl (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .in_point  (dbl_point),
        .out_point (dbl_out),
        .done      (dbl_done)
    );

    xadd_unit u_add (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .p_point   (p_point),
        .q_point   (q_point),
        .out_point (add_point),
        .done      (add_done)
    );

    assign both_fin = dbl_fin & add_fin;

    // Sticky finish flags, cleared together with the done pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            dbl_fin <= 1'b0;
            add_fin <= 1'b0;
            done    <= 1'b0;
        end else begin
            dbl_fin <= (dbl_fin & ~both_fin) | dbl_done;
            add_fin <= (add_fin & ~both_fin) | add_done;
            done    <= both_fin;
        end
    end

endmodule

// ==== ladder_step_sva.sv ====
`timescale 1ns/1ps

module ladder_step_sva (
    input logic clk,
    input logic reset,
    input logic done,
    input logic dbl_done,
    input logic add_done
);

    // ========================================
    // Top-level done pulse
    // ========================================
    done_single_cycle: assert property (
        @(posedge clk) disable iff (reset) done |=> !done
    ) else $error("done high for two cycles in a row");

    done_low_after_reset: assert property (
        @(posedge clk) reset |=> !done
    ) else $error("done high in the cycle after reset");

    // ========================================
    // Unit finish strobes
    // ========================================
    dbl_done_single_cycle: assert property (
        @(posedge clk) disable iff (reset) dbl_done |=> !dbl_done
    ) else $error("doubling unit done high for two cycles");

    add_done_single_cycle: assert property (
        @(posedge clk) disable iff (reset) add_done |=> !add_done
    ) else $error("addition unit done high for two cycles");

endmodule

bind ladder_step ladder_step_sva u_sva (
    .clk      (clk),
    .reset    (reset),
    .done     (done),
    .dbl_done (dbl_done),
    .add_done (add_done)
);

// ==== ladder_step_tb.sv ====
`timescale 1ns/1ps

module ladder_step_tb import ladder_pkg::*; ();

    logic      clk;
    logic      reset;
    logic      start;
    fe_point_t p_point;
    fe_point_t q_point;
    fe_point_t dbl_point;
    fe_point_t add_point;
    fe_point_t dbl_out;
    logic      done;

    logic [31:0] lfsr;

    // Table of stimulus and expected results
    fe_point_t rows_dbl[$];
    fe_point_t rows_p[$];
    fe_point_t rows_q[$];
    logic      rows_busy[$];
    fe_point_t rows_exp_dbl[$];
    fe_point_t rows_exp_add[$];

    ladder_step DUT (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .p_point   (p_point),
        .q_point   (q_point),
        .dbl_point (dbl_point),
        .add_point (add_point),
        .dbl_out   (dbl_out),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ========================================
    // Field reference model
    // ========================================
    function automatic fe_t mod_mul(input fe_t a, input fe_t b);
        logic [511:0] prod;
        prod = {257'd0, a} * {257'd0, b};
        return fe_t'(prod % {257'd0, PRIME});
    endfunction

    function automatic fe_t mod_add(input fe_t a, input fe_t b);
        logic [511:0] s;
        s = {257'd0, a} + {257'd0, b};
        return fe_t'(s % {257'd0, PRIME});
    endfunction

    function automatic fe_t mod_sub(input fe_t a, input fe_t b);
        logic [511:0] s;
        s = {257'd0, a} + {257'd0, PRIME} - {257'd0, b};
        return fe_t'(s % {257'd0, PRIME});
    endfunction

    function automatic fe_point_t model_dbl(input fe_point_t pt);
        fe_point_t r;
        fe_t       ss;
        fe_t       dd;
        fe_t       e;
        ss  = mod_mul(mod_add(pt.x, pt.z), mod_add(pt.x, pt.z));
        dd  = mod_mul(mod_sub(pt.x, pt.z), mod_sub(pt.x, pt.z));
        e   = mod_sub(ss, dd);
        r.x = mod_mul(ss, dd);
        // a24 = 121666
        r.z = mod_mul(e, mod_add(dd, mod_mul(fe_t'(121666), e)));
        return r;
    endfunction

    function automatic fe_point_t model_add(input fe_point_t pp, input fe_point_t qq);
        fe_point_t r;
        fe_t       da;
        fe_t       cb;
        fe_t       dm;
        da  = mod_mul(mod_add(pp.x, pp.z), mod_sub(qq.x, qq.z));
        cb  = mod_mul(mod_add(qq.x, qq.z), mod_sub(pp.x, pp.z));
        dm  = mod_sub(da, cb);
        r.x = mod_mul(mod_add(da, cb), mod_add(da, cb));
        r.z = mod_mul(fe_t'(9), mod_mul(dm, dm));
        return r;
    endfunction

    // ========================================
    // Random elements
    // ========================================
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        else
            return s >> 1;
    endfunction

    function automatic fe_t random_fe();
        fe_t v;
        int  k;
        v = '0;
        for (k = 0; k < FE_WIDTH; k++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[FE_WIDTH-2:0], lfsr[0]};
        end
        if (v >= PRIME)
            v = v - PRIME;
        return v;
    endfunction

    function automatic fe_point_t make_point(input fe_t x, input fe_t z);
        fe_point_t pt;
        pt.x = x;
        pt.z = z;
        return pt;
    endfunction

    function automatic fe_point_t random_point();
        fe_point_t pt;
        pt.x = random_fe();
        pt.z = random_fe();
        return pt;
    endfunction

    task automatic add_row(input fe_point_t d, input fe_point_t p, input fe_point_t q,
                           input logic busy);
        rows_dbl.push_back(d);
        rows_p.push_back(p);
        rows_q.push_back(q);
        rows_busy.push_back(busy);
        rows_exp_dbl.push_back(model_dbl(d));
        rows_exp_add.push_back(model_add(p, q));
    endtask

    // ========================================
    // Checking and driving
    // ========================================
    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_fe(input string name, input fe_t got, input fe_t exp);
        assert (got === exp)
        else fail_now($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp)
        else fail_now($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_outputs(input fe_point_t exp_dbl, input fe_point_t exp_add);
        check_fe("dbl_out.x", dbl_out.x, exp_dbl.x);
        check_fe("dbl_out.z", dbl_out.z, exp_dbl.z);
        check_fe("add_point.x", add_point.x, exp_add.x);
        check_fe("add_point.z", add_point.z, exp_add.z);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic pulse_start(input fe_point_t d, input fe_point_t p, input fe_point_t q);
        next_cycle();
        dbl_point = d;
        p_point   = p;
        q_point   = q;
        start     = 1'b1;
        next_cycle();
        start     = 1'b0;
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < 20000) begin
            next_cycle();
            cycles++;
        end
        if (done !== 1'b1)
            fail_now("Timeout: done never came within 20000 cycles");
    endtask

    task automatic run_row(input int i);
        fe_point_t exp_dbl;
        fe_point_t exp_add;
        exp_dbl = rows_exp_dbl[i];
        exp_add = rows_exp_add[i];
        pulse_start(rows_dbl[i], rows_p[i], rows_q[i]);
        if (rows_busy[i]) begin
            repeat (300) begin
                assert (done === 1'b0)
                else fail_now("done came long before the operation could have finished");
                next_cycle();
            end
            // Second start with other operands is ignored
            pulse_start(random_point(), random_point(), random_point());
        end
        wait_for_done();
        check_outputs(exp_dbl, exp_add);
        next_cycle();
        // Single done pulse and held results
        repeat (20) begin
            check_bit("done", done, 1'b0);
            check_outputs(exp_dbl, exp_add);
            next_cycle();
        end
    endtask

    initial begin
        reset     = 1'b1;
        start     = 1'b0;
        p_point   = '0;
        q_point   = '0;
        dbl_point = '0;
        lfsr      = 32'h6c47_6445;

        add_row(make_point(9, 1), make_point(9, 1), make_point(9, 1), 1'b0);
        // Differences wrap through p
        add_row(make_point(3, 7), make_point(2, 5), make_point(4, 11), 1'b0);
        add_row(make_point(1, PRIME - fe_t'(1)), make_point(5, PRIME - fe_t'(2)),
                make_point(0, PRIME - fe_t'(3)), 1'b0);
        for (int r = 0; r < 6; r++) begin
            add_row(random_point(), random_point(), random_point(), r == 2 || r == 5);
        end

        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        next_cycle();
        check_bit("done", done, 1'b0);
        check_outputs('0, '0);

        for (int i = 0; i < rows_dbl.size(); i++) begin
            run_row(i);
        end

        $display("Test passed");
        $finish;
    end

endmodule

// ==== list.f ====
ladder_pkg.sv
mul_serial.sv
mod_reduce_serial.sv
xdbl_unit.sv
xadd_unit.sv
ladder_step.sv
ladder_step_sva.sv
ladder_step_tb.sv

// ==== mod_reduce_serial.sv ====
`timescale 1ns/1ps

module mod_reduce_serial import ladder_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    input  wide_t value,
    output fe_t   result,
    output logic  done
);

    localparam int CNT_W = $clog2(WIDE_WIDTH);

    logic             busy;
    logic [CNT_W-1:0] count;
    wide_t            shreg;
    fe_t              rem;
    fe_ext_t          trial;

    // ========================================
    // Step counter
    // ========================================
    always_ff @(posedge clk) begin
        done <= 1'b0;
        if (reset) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            count <= '0;
        end else if (busy) begin
            count <= count + 1'b1;
            if (count == CNT_W'(WIDE_WIDTH - 1)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // ========================================
    // Restoring remainder
    // ========================================

    // rem < p, so the shifted trial value stays below 2p
    always_comb begin
        trial = {rem, shreg[WIDE_WIDTH-1]};
    end

    always_ff @(posedge clk) begin
        if (start) begin
            shreg <= value;
            rem   <= '0;
        end else if (busy) begin
            shreg <= shreg << 1;
            if (trial >= {1'b0, PRIME})
                rem <= fe_t'(trial - {1'b0, PRIME});
            else
                rem <= trial[FE_WIDTH-1:0];
        end
    end

    assign result = rem;

endmodule

// ==== mul_serial.sv ====
`timescale 1ns/1ps

module mul_serial import ladder_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    start,
    input  fe_ext_t a,
    input  fe_ext_t b,
    output wide_t   product,
    output logic    done
);

    localparam int CNT_W = $clog2(EXT_WIDTH);

    logic             busy;
    logic [CNT_W-1:0] count;
    wide_t            a_sh;
    fe_ext_t          b_sh;
    wide_t            acc;

    // Control
    always_ff @(posedge clk) begin
        done <= 1'b0;
        if (reset) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            count <= '0;
        end else if (busy) begin
            count <= count + 1'b1;
            if (count == CNT_W'(EXT_WIDTH - 1)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // One bit of b per cycle, a shifted up by one place
    always_ff @(posedge clk) begin
        if (start) begin
            a_sh <= {{(WIDE_WIDTH-EXT_WIDTH){1'b0}}, a};
            b_sh <= b;
            acc  <= '0;
        end else if (busy) begin
            if (b_sh[0])
                acc <= acc + a_sh;
            a_sh <= a_sh << 1;
            b_sh <= b_sh >> 1;
        end
    end

    assign product = acc;

endmodule

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f list.f --top-module ladder_step_tb -o sim || exit 1
./obj_dir/sim > sim.log 2>&1 || echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

// ==== xadd_unit.sv ====
`timescale 1ns/1ps

module xadd_unit import ladder_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  fe_point_t p_point,
    input  fe_point_t q_point,
    output fe_point_t out_point,
    output logic      done
);

    xadd_state_t state;

    logic    mul_start;
    fe_ext_t mul_a;
    fe_ext_t mul_b;
    wide_t   mul_product;
    logic    mul_done;
    logic    mul_ready;
    logic    mul_avail;

    logic    mod_start;
    fe_t     mod_result;
    logic    mod_done;

    // Intermediate terms
    fe_t     b_dif;
    fe_t     c_sum;
    fe_t     da;
    fe_t     dif;

    mul_serial u_mul (
        .clk     (clk),
        .reset   (reset),
        .start   (mul_start),
        .a       (mul_a),
        .b       (mul_b),
        .product (mul_product),
        .done    (mul_done)
    );

    mod_reduce_serial u_red (
        .clk    (clk),
        .reset  (reset),
        .start  (mod_start),
        .value  (mul_product),
        .result (mod_result),
        .done   (mod_done)
    );

    assign mul_avail = mul_done | mul_ready;

    always_ff @(posedge clk) begin
        mul_start <= 1'b0;
        mod_start <= 1'b0;
        done      <= 1'b0;
        if (reset) begin
            state     <= XA_IDLE;
            mul_ready <= 1'b0;
            out_point <= '0;
        end else begin
            if (mul_done)
                mul_ready <= 1'b1;
            case (state)
                // DA = (XP+ZP)*(XQ-ZQ) goes first
                XA_IDLE: if (start) begin
                    mul_a     <= {1'b0, fe_add(p_point.x, p_point.z)};
                    mul_b     <= {1'b0, fe_sub(q_point.x, q_point.z)};
                    b_dif     <= fe_sub(p_point.x, p_point.z);
                    c_sum     <= fe_add(q_point.x, q_point.z);
                    mul_start <= 1'b1;
                    mul_ready <= 1'b0;
                    state     <= XA_WAIT_M1;
                end
                XA_WAIT_M1: if (mul_avail) begin
                    mod_start <= 1'b1;
                    mul_a     <= {1'b0, c_sum};
                    mul_b     <= {1'b0, b_dif};
                    mul_start <= 1'b1;
                    mul_ready <= 1'b0;
                    state     <= XA_WAIT_R1;
                end
                XA_WAIT_R1: if (mod_done) begin
                    da    <= mod_result;
                    state <= XA_WAIT_M2;
                end
                XA_WAIT_M2: if (mul_avail) begin
                    mod_start <= 1'b1;
                    state     <= XA_WAIT_R2;
                end
                // CB ready, square DA+CB and keep DA-CB
                XA_WAIT_R2: if (mod_done) begin
                    mul_a     <= {1'b0, fe_add(da, mod_result)};
                    mul_b     <= {1'b0, fe_add(da, mod_result)};
                    dif       <= fe_sub(da, mod_result);
                    mul_start <= 1'b1;
                    mul_ready <= 1'b0;
                    state     <= XA_WAIT_M3;
                end
                XA_WAIT_M3: if (mul_avail) begin
                    mod_start <= 1'b1;
                    mul_a     <= {1'b0, dif};
                    mul_b     <= {1'b0, dif};
                    mul_start <= 1'b1;
                    mul_ready <= 1'b0;
                    state     <= XA_WAIT_R3;
                end
                XA_WAIT_R3: if (mod_done) begin
                    out_point.x <= mod_result;
                    state       <= XA_WAIT_M4;
                end
                XA_WAIT_M4: if (mul_avail) begin
                    mod_start <= 1'b1;
                    state     <= XA_WAIT_R4;
                end
                // Scale (DA-CB)^2 by the base point x
                XA_WAIT_R4: if (mod_done) begin
                    mul_a     <= {1'b0, mod_result};
                    mul_b     <= {1'b0, BASE_X};
                    mul_start <= 1'b1;
                    mul_ready <= 1'b0;
                    state     <= XA_WAIT_M5;
                end
                XA_WAIT_M5: if (mul_avail) begin
                    mod_start <= 1'b1;
                    state     <= XA_WAIT_R5;
                end
                XA_WAIT_R5: if (mod_done) begin
                    out_point.z <= mod_result;
                    done        <= 1'b1;
                    state       <= XA_IDLE;
                end
                default: state <= XA_IDLE;
            endcase
        end
    end

endmodule

// ==== xdbl_unit.sv ====
`timescale 1ns/1ps

module xdbl_unit import ladder_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  fe_point_t in_point,
    output fe_point_t out_point,
    output logic      done
);

    xdbl_state_t state;

    logic    mul_start;
    fe_ext_t mul_a;
    fe_ext_t mul_b;
    wide_t   mul_product;
    logic    mul_done;
    logic    mul_ready;
    logic    mul_avail;

    logic    mod_start;
    fe_t     mod_result;
    logic    mod_done;

    // Intermediate terms
    fe_t     dif;
    fe_t     sq_sum;
    fe_t     sq_dif;
    fe_t     e;

    mul_serial u_mul (
        .clk     (clk),
        .reset   (reset),
        .start   (mul_start),
        .a       (mul_a),
        .b       (mul_b),
        .product (mul_product),
        .done    (mul_done)
    );

    mod_reduce_serial u_red (
        .clk    (clk),
        .reset  (reset),
        .start  (mod_start),
        .value  (mul_product),
        .result (mod_result),
        .done   (mod_done)
    );

    // Multiplier may finish while the reducer is still busy
    assign mul_avail = mul_done | mul_ready;

    always_ff @(posedge clk) begin
        mul_start <= 1'b0;
        mod_start <= 1'b0;
        done      <= 1'b0;
        if (reset) begin
            state     <= XD_IDLE;
            mul_ready <= 1'b0;
            out_point <= '0;
        end else begin
            if (mul_done)
                mul_ready <= 1'b1;
            case (state)
                XD_IDLE: if (start) begin
                    mul_a     <= {1'b0, fe_add(in_point.x, in_point.z)};
                    mul_b     <= {1'b0, fe_add(in_point.x, in_point.z)};
                    dif       <= fe_sub(in_point.x, in_point.z);
                    mul_start <= 1'b1;
                    mul_ready <= 1'b0;
                    state     <= XD_WAIT_M1;
                end
                // (X+Z)^2 to reducer, (X-Z)^2 into multiplier
                XD_WAIT_M1: if (mul_avail) begin
                    mod_start <= 1'b1;
                    mul_a     <= {1'b0, dif};
                    mul_b     <= {1'b0, dif};
                    mul_start <= 1'b1;
                    mul_ready <= 1'b0;
                    state     <= XD_WAIT_R1;
                end
                XD_WAIT_R1: if (mod_done) begin
                    sq_sum <= mod_result;
                    state  <= XD_WAIT_M2;
                end
                XD_WAIT_M2: if (mul_avail) begin
                    mod_start <= 1'b1;
                    state     <= XD_WAIT_R2;
                end
                XD_WAIT_R2: if (mod_done) begin
                    sq_dif    <= mod_result;
                    e         <= fe_sub(sq_sum, mod_result);
                    mul_a     <= {1'b0, sq_sum};
                    mul_b     <= {1'b0, mod_result};
                    mul_start <= 1'b1;
                    mul_ready <= 1'b0;
                    state     <= XD_WAIT_M3;
                end
                XD_WAIT_M3: if (mul_avail) begin
                    mod_start <= 1'b1;
                    mul_a     <= {1'b0, e};
                    mul_b     <= {1'b0, A24};
                    mul_start <= 1'b1;
                    mul_ready <= 1'b0;
                    state     <= XD_WAIT_R3;
                end
                XD_WAIT_R3: if (mod_done) begin
                    out_point.x <= mod_result;
                    state       <= XD_WAIT_M4;
                end
                XD_WAIT_M4: if (mul_avail) begin
                    mod_start <= 1'b1;
                    state     <= XD_WAIT_R4;
                end
                // a24*E + (X-Z)^2, then times E
                XD_WAIT_R4: if (mod_done) begin
                    mul_a     <= {1'b0, fe_add(mod_result, sq_dif)};
                    mul_b     <= {1'b0, e};
                    mul_start <= 1'b1;
                    mul_ready <= 1'b0;
                    state     <= XD_WAIT_M5;
                end
                XD_WAIT_M5: if (mul_avail) begin
                    mod_start <= 1'b1;
                    state     <= XD_WAIT_R5;
                end
                XD_WAIT_R5: if (mod_done) begin
                    out_point.z <= mod_result;
                    done        <= 1'b1;
                    state       <= XD_IDLE;
                end
                default: state <= XD_IDLE;
            endcase
        end
    end

endmodule
